// ==== files.f ====
verilog/rv_core_pkg.sv
verilog/register_file.sv
verilog/core.sv
verilog/ram_io.sv
verilog/soc_top.sv
sim/flash_model.sv
sim/tb_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the rv32i system testbench with Verilator, runs it, and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_soc -f files.f -o tb_soc_sim > build.log 2>&1 ||
  { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_soc_sim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== sim/tb_soc.sv ====
// rv32i system testbench with a random program in flash and a reference model
// every io store is compared in order against the store the model expects
`timescale 1ns/100ps
`default_nettype none

module tb_soc;
  import rv_core_pkg::*;

  localparam int boot_wait   = 20;
  localparam int boot_len    = 1024;
  localparam int ram_len     = 1024;
  localparam int image_words = boot_len / 4;

  localparam logic [4:0] r_zero = 5'd0;
  localparam logic [4:0] r_a    = 5'd1;
  localparam logic [4:0] r_b    = 5'd2;
  localparam logic [4:0] r_res  = 5'd3;
  localparam logic [4:0] r_link = 5'd4;
  localparam logic [4:0] r_io   = 5'd10;  // holds io_base
  localparam logic [4:0] r_data = 5'd12;  // load/store scratch area

  logic        clk;
  logic        rst_n;
  wire         flash_clk;
  wire         flash_cs;
  wire         flash_mosi;
  wire         flash_miso;
  io_write_t   io_out;
  logic [31:0] lfsr;
  logic [31:0] prog [image_words];
  xlen_t       mref [ram_len];
  xlen_t       xr [32];
  io_write_t   expected [$];
  io_write_t   exp_st;
  int          pcw;
  int          cyc;
  int          limit;
  logic        cs_fell;
  logic        boot_done;

  soc_top #(
    .boot_wait_cycles (32'd20),
    .boot_bytes       (32'd1024),
    .ram_words        (ram_len)
  ) dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .flash_clk  (flash_clk),
    .flash_cs   (flash_cs),
    .flash_mosi (flash_mosi),
    .flash_miso (flash_miso),
    .io_out     (io_out)
  );

  flash_model #(
    .image_words (image_words)
  ) u_flash (
    .flash_clk  (flash_clk),
    .flash_cs   (flash_cs),
    .flash_mosi (flash_mosi),
    .flash_miso (flash_miso)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_alu_reg};
  endfunction

  function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_u(input logic [31:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm[19:0], rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  task automatic emit(input logic [31:0] w);
    prog[pcw] = w;
    pcw++;
  endtask

  task automatic set_reg(input logic [4:0] rd);
    emit(enc_u(rand_bits(20), rd, op_lui));
    emit(enc_i(rand_bits(12), rd, 3'd0, rd, op_alu_imm));
  endtask

  task automatic build_program();
    logic [31:0] imm;
    logic [31:0] bitv;
    logic [2:0]  f3;
    int          kind;
    int          sel;
    emit(enc_u(32'h80000, r_io, op_lui));
    emit(enc_i(32'h400, r_zero, 3'd0, r_data, op_alu_imm));
    while (pcw + 7 <= image_words - 1) begin  // room for the largest group and the end loop
      kind = rand_bits(3);
      f3   = rand_bits(3);
      case (kind)
        0: begin
          set_reg(r_a);
          imm = rand_bits(12);
          if (f3 == 3'd1) imm = {27'd0, imm[4:0]};
          else if (f3 == 3'd5) imm = {21'd0, imm[10], 5'd0, imm[4:0]};  // bit 30 picks sra
          emit(enc_i(imm, r_a, f3, r_res, op_alu_imm));
        end
        2: emit(enc_u(rand_bits(20), r_res, (f3[0] ? op_lui : op_auipc)));
        3: begin
          set_reg(r_a);
          if (f3[1:0] == 2'b00) emit(enc_i(32'd0, r_a, 3'd0, r_b, op_alu_imm));
          else set_reg(r_b);
          f3 = rand_bits(3);
          if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // no branch uses 2 or 3
          emit(enc_b(32'd8, r_b, r_a, f3));
          emit(enc_s(32'd4, r_a, r_io, 3'd2));  // marker store skipped when taken
          emit(enc_s(32'd0, r_b, r_io, 3'd2));
        end
        4: begin
          if (f3[0]) begin
            emit(enc_j(32'd8, r_res));
          end else begin
            emit(enc_u(32'd0, r_link, op_auipc));
            emit(enc_i(32'd12, r_link, 3'd0, r_res, op_jalr));
          end
          emit(enc_s(32'd4, r_zero, r_io, 3'd2));
        end
        5: begin
          set_reg(r_a);
          imm = rand_bits(4) << 2;
          emit(enc_s(imm, r_a, r_data, 3'd2));
          sel = rand_bits(3) % 5;
          case (sel)
            0: begin
              f3  = 3'd0;
              imm = imm + rand_bits(2);
            end
            1: begin
              f3  = 3'd4;
              imm = imm + rand_bits(2);
            end
            2: begin
              f3  = 3'd1;
              imm = imm + (rand_bits(1) << 1);
            end
            3: begin
              f3  = 3'd5;
              imm = imm + (rand_bits(1) << 1);
            end
            default: f3 = 3'd2;
          endcase
          emit(enc_i(imm, r_data, f3, r_res, op_load));
        end
        6: begin
          set_reg(r_a);
          if (f3[0]) emit(enc_s(rand_bits(2), r_a, r_io, 3'd0));
          else emit(enc_s(rand_bits(1) << 1, r_a, r_io, 3'd1));
        end
        default: begin
          set_reg(r_a);
          set_reg(r_b);
          bitv = rand_bits(1);
          emit(enc_r({1'b0, bitv[0] & (f3 == 3'd0 || f3 == 3'd5), 5'd0}, r_b, r_a, f3, r_res));
        end
      endcase
      if (kind != 3 && kind != 6) emit(enc_s(32'd0, r_res, r_io, 3'd2));  // result out
    end
    emit(enc_j(32'd0, r_zero));  // park here
    for (int i = pcw; i < image_words; i++) begin
      prog[i] = enc_i(i, r_zero, 3'd0, r_zero, op_alu_imm);
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH time=%0t %s got=%08h expected=%08h",
                         $time, name, got, exp));
    end
  endtask

  // instruction level model that produces the expected io stores
  task automatic run_model();
    xlen_t        pc;
    xlen_t        npc;
    xlen_t        ins;
    xlen_t        a;
    xlen_t        b;
    xlen_t        res;
    xlen_t        w;
    xlen_t        addr;
    xlen_t        imm_i;
    xlen_t        imm_s;
    xlen_t        imm_b;
    xlen_t        imm_u;
    xlen_t        imm_j;
    logic [4:0]   rd;
    logic [4:0]   rs1;
    logic [4:0]   rs2;
    logic [2:0]   f3;
    logic [6:0]   op;
    logic         wr;
    int           steps;
    int           nbytes;
    access_size_e sz;
    for (int i = 0; i < ram_len; i++) mref[i] = (i < image_words) ? prog[i] : '0;
    for (int i = 0; i < 32; i++) xr[i] = '0;
    pc = '0;
    for (steps = 0; steps < 20000; steps++) begin
      ins = mref[pc[11:2]];
      if (ins == enc_j(32'd0, r_zero)) break;
      op    = ins[6:0];
      rd    = ins[11:7];
      f3    = ins[14:12];
      rs1   = ins[19:15];
      rs2   = ins[24:20];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_u = {ins[31:12], 12'd0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      a     = xr[rs1];
      b     = (op == op_alu_reg) ? xr[rs2] : imm_i;
      npc   = pc + 32'd4;
      res   = '0;
      wr    = 1'b1;
      case (op)
        op_lui:   res = imm_u;
        op_auipc: res = pc + imm_u;
        op_jal: begin
          res = pc + 32'd4;
          npc = pc + imm_j;
        end
        op_jalr: begin
          res = pc + 32'd4;
          npc = (a + imm_i) & ~32'd1;
        end
        op_branch: begin
          wr = 1'b0;
          case (f3)
            3'd0: if (a == xr[rs2]) npc = pc + imm_b;
            3'd1: if (a != xr[rs2]) npc = pc + imm_b;
            3'd4: if ($signed(a) < $signed(xr[rs2])) npc = pc + imm_b;
            3'd5: if ($signed(a) >= $signed(xr[rs2])) npc = pc + imm_b;
            3'd6: if (a < xr[rs2]) npc = pc + imm_b;
            3'd7: if (a >= xr[rs2]) npc = pc + imm_b;
            default: ;
          endcase
        end
        op_load: begin
          addr = a + imm_i;
          w    = (addr >= io_base) ? '0 : mref[addr[11:2]] >> {addr[1:0], 3'b000};
          case (f3)
            3'd0:    res = {{24{w[7]}}, w[7:0]};
            3'd4:    res = {24'd0, w[7:0]};
            3'd1:    res = {{16{w[15]}}, w[15:0]};
            3'd5:    res = {16'd0, w[15:0]};
            default: res = w;
          endcase
        end
        op_store: begin
          wr   = 1'b0;
          addr = a + imm_s;
          case (f3[1:0])
            2'b00: begin
              nbytes = 1;
              sz     = size_byte;
              w      = {24'd0, xr[rs2][7:0]};
            end
            2'b01: begin
              nbytes = 2;
              sz     = size_half;
              w      = {16'd0, xr[rs2][15:0]};
            end
            default: begin
              nbytes = 4;
              sz     = size_word;
              w      = xr[rs2];
            end
          endcase
          if (addr >= io_base) begin
            expected.push_back('{valid: 1'b1, address: addr,
                                 data: w << {addr[1:0], 3'b000}, size: sz});
          end else begin
            for (int k = 0; k < nbytes; k++) begin
              mref[addr[11:2]][8 * (addr[1:0] + k) +: 8] = w[8 * k +: 8];
            end
          end
        end
        op_alu_imm, op_alu_reg: begin
          case (f3)
            3'd0:    res = (op == op_alu_reg && ins[30]) ? a - b : a + b;
            3'd1:    res = a << b[4:0];
            3'd2:    res = {31'd0, $signed(a) < $signed(b)};
            3'd3:    res = {31'd0, a < b};
            3'd4:    res = a ^ b;
            3'd5:    res = ins[30] ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    res = a | b;
            default: res = a & b;
          endcase
        end
        default: wr = 1'b0;
      endcase
      if (wr && rd != 5'd0) xr[rd] = res;
      pc = npc;
    end
    if (steps >= 20000) fail_run("reference model never reached the end of the program");
  endtask

  // io port monitor with the flash_cs and valid checks around boot
  always @(negedge clk) begin
    cyc <= cyc + 1;
    // flash_cs falls on the last clock edge of the wait
    if (cyc < 16 + boot_wait - 1 && (flash_cs !== 1'b1 || io_out.valid !== 1'b0)) begin
      fail_run("flash_cs low or io store during reset or boot wait");
    end else if (rst_n && io_out.valid) begin
      if (!boot_done) begin
        fail_run("io store seen before the boot copy finished");
      end else if (expected.size() == 0) begin
        fail_run("io store seen after the expected sequence ended");
      end else begin
        exp_st = expected.pop_front();
        check_equal("io_out.address", io_out.address, exp_st.address);
        check_equal("io_out.data", io_out.data, exp_st.data);
        check_equal("io_out.size", {30'd0, io_out.size}, {30'd0, exp_st.size});
      end
    end
    if (!flash_cs) cs_fell <= 1'b1;
    if (cs_fell && flash_cs) boot_done <= 1'b1;
  end

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    lfsr      = 32'd40;
    pcw       = 0;
    cyc       = 0;
    cs_fell   = 1'b0;
    boot_done = 1'b0;
    build_program();
    for (int i = 0; i < image_words; i++) u_flash.image[i] = prog[i];
    run_model();
    limit = boot_len * 70 + boot_wait + 16 + 200 * expected.size();
    $display("program of %0d words, %0d io stores expected", pcw, expected.size());
    fork
      begin
        repeat (limit) @(posedge clk);
        fail_run($sformatf("run ended with %0d io stores missing", expected.size()));
      end
    join_none
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    while (expected.size() != 0) @(negedge clk);
    repeat (200) @(negedge clk);  // catches stray stores
    check_equal("flash command", u_flash.cmd_addr, 32'h0300_0000);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/flash_model.sv ====
// spi serial flash model for the boot copy, read command only
// the testbench fills image before reset, bytes leave little endian from each word
`timescale 1ns/100ps
`default_nettype none

module flash_model #(
  parameter int image_words = 256
) (
  input  wire  flash_clk,
  input  wire  flash_cs,
  input  wire  flash_mosi,
  output logic flash_miso
);

  logic [31:0] image [image_words];
  logic [31:0] cmd_addr;  // command byte and 24 address bits as received
  int          rise_cnt;
  int          bit_idx;

  initial begin
    rise_cnt   = 0;
    bit_idx    = 0;
    cmd_addr   = '0;
    flash_miso = 1'b0;
  end

  // mode 0, mosi taken on the rising edge
  always @(posedge flash_clk) begin
    if (!flash_cs) begin
      if (rise_cnt < 32) begin
        cmd_addr <= {cmd_addr[30:0], flash_mosi};
      end
      rise_cnt <= rise_cnt + 1;
    end
  end

  // data bits leave on the falling edge, msb of each byte first
  always @(negedge flash_clk) begin
    if (!flash_cs && rise_cnt >= 32) begin
      bit_idx = rise_cnt - 32;
      if (bit_idx < image_words * 32) begin
        flash_miso <= image[bit_idx / 32][8 * ((bit_idx / 8) % 4) + 7 - bit_idx % 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/soc_top.sv ====
// rv32i system top, core plus ram/io block
// boots from spi flash and reports results through the io_out store port
`timescale 1ns/100ps
`default_nettype none

module soc_top #(
  parameter logic [31:0] boot_wait_cycles = 32'd1000,
  parameter logic [31:0] boot_bytes       = 32'd4096,
  parameter int          ram_words        = 1024
) (
  input  wire                         clk,
  input  wire                         rst_n,
  output wire                         flash_clk,
  output wire                         flash_cs,
  output wire                         flash_mosi,
  input  wire                         flash_miso,
  output wire rv_core_pkg::io_write_t io_out
);
  import rv_core_pkg::*;

  mem_req_t mem_req;
  xlen_t    mem_rdata;
  logic     mem_data_ready;
  logic     mem_busy;

  core #(
    .boot_wait_cycles (boot_wait_cycles),
    .boot_bytes       (boot_bytes)
  ) u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_req        (mem_req),
    .mem_rdata      (mem_rdata),
    .mem_data_ready (mem_data_ready),
    .mem_busy       (mem_busy),
    .flash_clk      (flash_clk),
    .flash_cs       (flash_cs),
    .flash_mosi     (flash_mosi),
    .flash_miso     (flash_miso)
  );

  ram_io #(
    .ram_words (ram_words)
  ) u_ram_io (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (mem_req),
    .rdata      (mem_rdata),
    .data_ready (mem_data_ready),
    .busy       (mem_busy),
    .io_out     (io_out)
  );

endmodule

`default_nettype wire

// ==== verilog/ram_io.sv ====
// on-chip word ram with byte lanes plus the memory mapped io window
// serves the core's mem_req_t, stores at io_base and above go out on io_out
`timescale 1ns/100ps
`default_nettype none

module ram_io #(
  parameter int ram_words = 1024
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire rv_core_pkg::mem_req_t req,
  output rv_core_pkg::xlen_t        rdata,
  output logic                      data_ready,
  output logic                      busy,
  output rv_core_pkg::io_write_t    io_out
);
  import rv_core_pkg::*;

  localparam int addr_bits = $clog2(ram_words);

  xlen_t                mem [ram_words];
  logic [addr_bits-1:0] word_idx;
  logic [4:0]           byte_shift;
  logic                 is_io;
  logic                 accept;
  logic                 accept_wr;
  logic                 accept_rd;
  xlen_t                size_data;
  logic [3:0]           size_be;
  xlen_t                lane_data;
  logic [3:0]           lane_be;
  xlen_t                shifted;
  xlen_t                rd_ext;
  logic                 busy_q;
  logic                 rd_valid_q;
  mem_req_t             rd_req_q;  // last read taken
  logic                 io_valid_q;
  xlen_t                io_addr_q;
  xlen_t                io_data_q;
  access_size_e         io_size_q;

  assign word_idx   = req.address[addr_bits+1:2];
  assign byte_shift = {req.address[1:0], 3'b000};
  assign is_io      = (req.address >= io_base);
  assign accept     = req.enable && !busy_q;
  assign accept_wr  = accept && (req.write_size != size_none);
  assign accept_rd  = accept && (req.read_size != size_none);

  always_comb begin
    case (req.write_size)
      size_byte: begin
        size_data = {24'd0, req.wdata[7:0]};
        size_be   = 4'b0001;
      end
      size_half: begin
        size_data = {16'd0, req.wdata[15:0]};
        size_be   = 4'b0011;
      end
      default: begin
        size_data = req.wdata;
        size_be   = 4'b1111;
      end
    endcase
    lane_data = size_data << byte_shift;
    lane_be   = size_be << req.address[1:0];
  end

  always_comb begin
    shifted = mem[word_idx] >> byte_shift;
    case (req.read_size)
      size_byte: rd_ext = {{24{req.read_signed & shifted[7]}}, shifted[7:0]};
      size_half: rd_ext = {{16{req.read_signed & shifted[15]}}, shifted[15:0]};
      default:   rd_ext = shifted;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      rd_valid_q <= 1'b0;
      io_valid_q <= 1'b0;
    end else begin
      busy_q     <= accept_wr;  // one cycle per write
      rd_valid_q <= accept_rd;
      io_valid_q <= accept_wr && is_io;
    end
  end

  always_ff @(posedge clk) begin
    if (accept_rd) begin
      rd_req_q <= req;
      rdata    <= is_io ? '0 : rd_ext;
    end
    if (accept_wr && !is_io) begin
      for (int i = 0; i < 4; i++) begin
        if (lane_be[i]) begin
          mem[word_idx][i*8 +: 8] <= lane_data[i*8 +: 8];
        end
      end
    end
    if (accept_wr) begin
      io_addr_q <= req.address;
      io_data_q <= lane_data;
      io_size_q <= req.write_size;
    end
  end

  // ready only while the core still holds the read that produced rdata
  assign data_ready = rd_valid_q && (req == rd_req_q);
  assign busy       = busy_q;
  assign io_out     = '{valid: io_valid_q, address: io_addr_q, data: io_data_q,
                        size: io_size_q};

endmodule

`default_nettype wire

// ==== verilog/core.sv ====
// reduced multi-cycle rv32i core with a flash boot loader
// copies boot_bytes from spi flash address 0 into ram, then runs from ram address 0
`timescale 1ns/100ps
`default_nettype none

module core #(
  parameter logic [31:0] boot_wait_cycles = 32'd1000,
  parameter logic [31:0] boot_bytes       = 32'd4096
) (
  input  wire                     clk,
  input  wire                     rst_n,
  output rv_core_pkg::mem_req_t   mem_req,
  input  wire rv_core_pkg::xlen_t mem_rdata,
  input  wire                     mem_data_ready,
  input  wire                     mem_busy,
  output logic                    flash_clk,
  output logic                    flash_cs,
  output logic                    flash_mosi,
  input  wire                     flash_miso
);
  import rv_core_pkg::*;

  localparam logic [9:0] st_boot_wait = 10'b00_0000_0001;
  localparam logic [9:0] st_cmd       = 10'b00_0000_0010;
  localparam logic [9:0] st_addr      = 10'b00_0000_0100;
  localparam logic [9:0] st_recv      = 10'b00_0000_1000;
  localparam logic [9:0] st_ram_write = 10'b00_0001_0000;
  localparam logic [9:0] st_fetch     = 10'b00_0010_0000;
  localparam logic [9:0] st_execute   = 10'b00_0100_0000;
  localparam logic [9:0] st_store     = 10'b00_1000_0000;
  localparam logic [9:0] st_load      = 10'b01_0000_0000;
  localparam logic [9:0] st_load_wb   = 10'b10_0000_0000;

  logic [9:0]  state;
  logic [31:0] wait_cnt;
  logic [31:0] tx_shift;   // command then address, msb first
  logic [30:0] rx_shift;
  logic [31:0] rx_next;
  logic [5:0]  bit_cnt;
  logic        sck_phase;  // 0 drives flash_clk low, 1 drives it high
  xlen_t       boot_addr;
  xlen_t       boot_word;

  xlen_t  pc;
  xlen_t  pc_plus4;
  instr_u ir;
  xlen_t  rs1_data;
  xlen_t  rs2_data;
  xlen_t  rd_wdata;
  logic   rd_we;
  logic   is_alu_reg;
  xlen_t  imm_i;
  xlen_t  imm_s;
  xlen_t  imm_b;
  xlen_t  imm_u;
  xlen_t  imm_j;
  xlen_t  alu_b;
  xlen_t  alu_result;
  logic   take_branch;
  xlen_t  next_pc;
  xlen_t  eff_addr;

  function automatic mem_req_t read_req(xlen_t addr, access_size_e size, logic sgn);
    read_req = '{enable: 1'b1, write_size: size_none, read_size: size,
                 read_signed: sgn, address: addr, wdata: '0};
  endfunction

  function automatic mem_req_t write_req(xlen_t addr, access_size_e size, xlen_t data);
    write_req = '{enable: 1'b1, write_size: size, read_size: size_none,
                  read_signed: 1'b0, address: addr, wdata: data};
  endfunction

  // funct3[1:0] of loads and stores
  function automatic access_size_e size_of(logic [1:0] f3);
    case (f3)
      2'b00:   size_of = size_byte;
      2'b01:   size_of = size_half;
      default: size_of = size_word;
    endcase
  endfunction

  // flash sends byte 0 first, ram word is little endian
  assign rx_next   = {rx_shift, flash_miso};
  assign boot_word = {rx_next[7:0], rx_next[15:8], rx_next[23:16], rx_next[31:24]};

  assign imm_i = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
  assign imm_s = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
  assign imm_b = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_lo[0], ir.s_fmt.imm_hi[5:0],
                  ir.s_fmt.imm_lo[4:1], 1'b0};
  assign imm_u = {ir.u_fmt.imm, 12'h000};
  assign imm_j = {{12{ir.u_fmt.imm[19]}}, ir.u_fmt.imm[7:0], ir.u_fmt.imm[8],
                  ir.u_fmt.imm[18:9], 1'b0};

  assign pc_plus4   = pc + 32'd4;
  assign is_alu_reg = (ir.r_fmt.opcode == op_alu_reg);
  assign alu_b      = is_alu_reg ? rs2_data : imm_i;
  assign eff_addr   = rs1_data + ((ir.r_fmt.opcode == op_store) ? imm_s : imm_i);

  always_comb begin
    case (ir.r_fmt.funct3)
      3'b000: begin  // sub only in the register form
        alu_result = (is_alu_reg && ir.r_fmt.funct7[5]) ? rs1_data - alu_b : rs1_data + alu_b;
      end
      3'b001:  alu_result = rs1_data << alu_b[4:0];
      3'b010:  alu_result = {31'd0, $signed(rs1_data) < $signed(alu_b)};
      3'b011:  alu_result = {31'd0, rs1_data < alu_b};
      3'b100:  alu_result = rs1_data ^ alu_b;
      3'b101: begin  // bit 30 picks arithmetic shift
        alu_result = ir.r_fmt.funct7[5] ? xlen_t'($signed(rs1_data) >>> alu_b[4:0])
                                        : rs1_data >> alu_b[4:0];
      end
      3'b110:  alu_result = rs1_data | alu_b;
      default: alu_result = rs1_data & alu_b;
    endcase
  end

  always_comb begin
    case (ir.r_fmt.funct3)
      3'b000:  take_branch = (rs1_data == rs2_data);
      3'b001:  take_branch = (rs1_data != rs2_data);
      3'b100:  take_branch = ($signed(rs1_data) < $signed(rs2_data));
      3'b101:  take_branch = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  take_branch = (rs1_data < rs2_data);
      3'b111:  take_branch = (rs1_data >= rs2_data);
      default: take_branch = 1'b0;
    endcase
  end

  always_comb begin
    case (ir.r_fmt.opcode)
      op_jal:    next_pc = pc + imm_j;
      op_jalr:   next_pc = (rs1_data + imm_i) & ~32'd1;
      op_branch: next_pc = take_branch ? pc + imm_b : pc_plus4;
      default:   next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_boot_wait;
      wait_cnt   <= '0;
      tx_shift   <= '0;
      rx_shift   <= '0;
      bit_cnt    <= '0;
      sck_phase  <= 1'b0;
      boot_addr  <= '0;
      flash_clk  <= 1'b0;
      flash_cs   <= 1'b1;
      flash_mosi <= 1'b0;
      mem_req    <= '0;
      pc         <= '0;
      ir         <= '0;
      rd_wdata   <= '0;
      rd_we      <= 1'b0;
    end else begin
      case (state)
        st_boot_wait: begin
          if (wait_cnt == boot_wait_cycles - 32'd1) begin
            flash_cs  <= 1'b0;
            tx_shift  <= 32'h0300_0000;  // read command, address 0
            bit_cnt   <= 6'd8;
            sck_phase <= 1'b0;
            state     <= st_cmd;
          end else begin
            wait_cnt <= wait_cnt + 32'd1;
          end
        end
        st_cmd, st_addr: begin
          sck_phase <= ~sck_phase;
          if (!sck_phase) begin
            flash_clk  <= 1'b0;
            flash_mosi <= tx_shift[31];
            tx_shift   <= {tx_shift[30:0], 1'b0};
            bit_cnt    <= bit_cnt - 6'd1;
          end else begin
            flash_clk <= 1'b1;  // flash samples mosi here
            if (bit_cnt == 6'd0) begin
              if (state == st_cmd) begin
                bit_cnt <= 6'd24;
                state   <= st_addr;
              end else begin
                bit_cnt <= 6'd32;
                state   <= st_recv;
              end
            end
          end
        end
        st_recv: begin
          sck_phase <= ~sck_phase;
          if (!sck_phase) begin
            flash_clk <= 1'b0;  // flash shifts out the next bit
          end else begin
            flash_clk <= 1'b1;
            rx_shift  <= rx_next[30:0];
            bit_cnt   <= bit_cnt - 6'd1;
            if (bit_cnt == 6'd1) begin
              mem_req <= write_req(boot_addr, size_word, boot_word);
              state   <= st_ram_write;
            end
          end
        end
        st_ram_write: begin
          if (!mem_busy) begin
            mem_req   <= '0;
            boot_addr <= boot_addr + 32'd4;
            if (boot_addr + 32'd4 < boot_bytes) begin
              bit_cnt <= 6'd32;
              state   <= st_recv;
            end else begin
              flash_cs  <= 1'b1;
              flash_clk <= 1'b0;
              pc        <= '0;
              mem_req   <= read_req('0, size_word, 1'b0);  // first fetch
              state     <= st_fetch;
            end
          end
        end
        st_fetch: begin
          rd_we <= 1'b0;  // ends the write of the previous instruction
          if (mem_data_ready) begin
            ir    <= mem_rdata;
            state <= st_execute;
          end
        end
        st_execute: begin
          pc      <= next_pc;
          mem_req <= read_req(next_pc, size_word, 1'b0);
          state   <= st_fetch;
          case (ir.r_fmt.opcode)
            op_lui: begin
              rd_wdata <= imm_u;
              rd_we    <= 1'b1;
            end
            op_auipc: begin
              rd_wdata <= pc + imm_u;
              rd_we    <= 1'b1;
            end
            op_jal, op_jalr: begin
              rd_wdata <= pc_plus4;  // link
              rd_we    <= 1'b1;
            end
            op_alu_imm, op_alu_reg: begin
              rd_wdata <= alu_result;
              rd_we    <= 1'b1;
            end
            op_store: begin
              mem_req <= write_req(eff_addr, size_of(ir.r_fmt.funct3[1:0]), rs2_data);
              state   <= st_store;
            end
            op_load: begin
              mem_req <= read_req(eff_addr, size_of(ir.r_fmt.funct3[1:0]),
                                  ~ir.r_fmt.funct3[2]);
              state   <= st_load;
            end
            default: ;  // unknown opcodes fall through as nops
          endcase
        end
        st_store: begin
          if (!mem_busy) begin
            mem_req <= read_req(pc, size_word, 1'b0);
            state   <= st_fetch;
          end
        end
        st_load: begin
          if (mem_data_ready) begin
            rd_wdata <= mem_rdata;  // already extended by ram_io
            rd_we    <= 1'b1;
            state    <= st_load_wb;
          end
        end
        st_load_wb: begin
          rd_we   <= 1'b0;
          mem_req <= read_req(pc, size_word, 1'b0);
          state   <= st_fetch;
        end
        default: state <= st_boot_wait;
      endcase
    end
  end

  register_file u_register_file (
    .clk      (clk),
    .rs1      (ir.r_fmt.rs1),
    .rs2      (ir.r_fmt.rs2),
    .rd       (ir.r_fmt.rd),
    .rd_wdata (rd_wdata),
    .rd_we    (rd_we),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
// rv32i integer register file, two combinational reads and one clocked write
// x0 always reads as zero
`timescale 1ns/100ps
`default_nettype none

module register_file (
  input  wire                rv_core_pkg::xlen_t rd_wdata,
  input  wire                clk,
  input  wire          [4:0] rs1,
  input  wire          [4:0] rs2,
  input  wire          [4:0] rd,
  input  wire                rd_we,
  output rv_core_pkg::xlen_t rs1_data,
  output rv_core_pkg::xlen_t rs2_data
);
  import rv_core_pkg::*;

  xlen_t regs [32];

  always_ff @(posedge clk) begin
    if (rd_we && rd != 5'd0) begin  // x0 is never written
      regs[rd] <= rd_wdata;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== verilog/rv_core_pkg.sv ====
// shared types and constants for the rv32i core, its memory port and the io window
// imported by the rtl modules and the testbench
`default_nettype none

package rv_core_pkg;

  typedef logic [31:0] xlen_t;

  // width of a memory access, none means no read or no write
  typedef enum logic [1:0] {
    size_none = 2'b00,
    size_byte = 2'b01,
    size_half = 2'b10,
    size_word = 2'b11
  } access_size_e;

  typedef struct packed {
    logic         enable;
    access_size_e write_size;
    access_size_e read_size;
    logic         read_signed;  // sign extend byte and half reads
    xlen_t        address;      // byte address
    xlen_t        wdata;        // store data in the low bits
  } mem_req_t;

  typedef struct packed {
    logic         valid;
    xlen_t        address;
    xlen_t        data;  // lane aligned
    access_size_e size;
  } io_write_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // b and j immediates come out of the s and u views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
  } instr_u;

  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_auipc   = 7'b0010111;
  localparam logic [6:0] op_jal     = 7'b1101111;
  localparam logic [6:0] op_jalr    = 7'b1100111;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_load    = 7'b0000011;
  localparam logic [6:0] op_store   = 7'b0100011;
  localparam logic [6:0] op_alu_imm = 7'b0010011;
  localparam logic [6:0] op_alu_reg = 7'b0110011;

  localparam xlen_t io_base = 32'h8000_0000;  // stores from here up leave the chip

endpackage

`default_nettype wire
